// File: hw/arcade_pkg.sv
package arcade_pkg;

	//==========================================================================
	// Host register map
	//==========================================================================
	localparam logic [1:0] REG_STATUS = 2'd0;
	localparam logic [1:0] REG_ID     = 2'd1;

	// Bit positions inside the 32-bit settings word
	localparam int STATUS_BIT_RESET  = 0;
	localparam int STATUS_BIT_ROTATE = 2;
	localparam int STATUS_SCAN_LO    = 3;
	localparam int STATUS_SCAN_HI    = 4;
	localparam int STATUS_BIT_BLEND  = 5;

	localparam logic [31:0] BUILD_ID = 32'h1a0c_0110;

	//==========================================================================
	// Video timing counted in pixels and lines
	//==========================================================================
	localparam int CE_DIV       = 2;
	localparam int H_ACTIVE     = 16;
	localparam int H_SYNC_START = 18;
	localparam int H_SYNC_LEN   = 2;
	localparam int H_TOTAL      = 24;
	localparam int V_ACTIVE     = 8;
	localparam int V_SYNC_START = 9;
	localparam int V_SYNC_LEN   = 1;
	localparam int V_TOTAL      = 12;
	localparam int H_BITS       = $clog2(H_TOTAL);
	localparam int V_BITS       = $clog2(V_TOTAL);

	localparam int AUDIO_BITS = 9;

	typedef enum logic [0:0] {
		WB_IDLE = 1'b0,
		WB_ACK  = 1'b1
	} wb_state_t;

	// Dimming strength on odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scan_mode_t;

endpackage

// File: hw/shell_if.sv
`timescale 1ns/1ps

// Pixel enable, sync and blanking from the timing generator
interface vid_timing_if;
	logic ce_pix;
	logic hs;
	logic vs;
	logic hb;
	logic vb;
	logic odd_line;

	modport source (
		output ce_pix, hs, vs, hb, vb, odd_line
	);

	modport sink (
		input ce_pix, hs, vs, hb, vb, odd_line
	);
endinterface

// Menu settings decoded from the host settings register
interface shell_cfg_if;
	logic                   core_reset;
	logic                   rotate;
	arcade_pkg::scan_mode_t scanlines;
	logic                   blend;

	modport source (
		output core_reset, rotate, scanlines, blend
	);

	modport sink (
		input core_reset, rotate, scanlines, blend
	);
endinterface

// File: hw/host_regs.sv
`timescale 1ns/1ps

module host_regs (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	shell_cfg_if.source cfg
);

	arcade_pkg::wb_state_t state;
	logic [31:0]           status;
	logic                  req;

	// A request is only taken from idle, so ack never lasts two cycles
	assign req = wb_cyc && wb_stb && (state == arcade_pkg::WB_IDLE);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state  <= arcade_pkg::WB_IDLE;
			status <= '0;
		end else begin
			case (state)
				arcade_pkg::WB_IDLE: begin
					if (req) begin
						state <= arcade_pkg::WB_ACK;
						// Writes land on the same edge that raises ack
						if (wb_we && (wb_adr == arcade_pkg::REG_STATUS)) begin
							status <= wb_dat_w;
						end
					end
				end
				arcade_pkg::WB_ACK: begin
					state <= arcade_pkg::WB_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req) begin
			case (wb_adr)
				arcade_pkg::REG_STATUS: wb_dat_r <= status;
				arcade_pkg::REG_ID:     wb_dat_r <= arcade_pkg::BUILD_ID;
				default:                wb_dat_r <= '0;
			endcase
		end
	end

	assign wb_ack = (state == arcade_pkg::WB_ACK);

	assign cfg.core_reset = status[arcade_pkg::STATUS_BIT_RESET];
	assign cfg.rotate     = status[arcade_pkg::STATUS_BIT_ROTATE];
	assign cfg.scanlines  = arcade_pkg::scan_mode_t'(
		status[arcade_pkg::STATUS_SCAN_HI:arcade_pkg::STATUS_SCAN_LO]);
	assign cfg.blend      = status[arcade_pkg::STATUS_BIT_BLEND];

endmodule

// File: hw/video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic         clk_sys,
	input  logic         arst_n,
	vid_timing_if.source tim
);

	logic [$clog2(arcade_pkg::CE_DIV)-1:0] ce_cnt;
	logic [arcade_pkg::H_BITS-1:0]         h_cnt;
	logic [arcade_pkg::V_BITS-1:0]         v_cnt;
	logic                                  ce_pix;
	logic                                  h_last;
	logic                                  v_last;

	assign h_last = (int'(h_cnt) == arcade_pkg::H_TOTAL - 1);
	assign v_last = (int'(v_cnt) == arcade_pkg::V_TOTAL - 1);

	//==========================================================================
	// Pixel enable divider
	//==========================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce_cnt <= '0;
			ce_pix <= 1'b0;
		end else begin
			if (int'(ce_cnt) == arcade_pkg::CE_DIV - 1) begin
				ce_cnt <= '0;
			end else begin
				ce_cnt <= ce_cnt + 1'b1;
			end
			ce_pix <= (int'(ce_cnt) == arcade_pkg::CE_DIV - 1);
		end
	end

	// Both counters step once per pixel and wrap at the frame edge
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (ce_pix) begin
			if (h_last) begin
				h_cnt <= '0;
				v_cnt <= v_last ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign tim.ce_pix   = ce_pix;
	assign tim.hs       = (int'(h_cnt) >= arcade_pkg::H_SYNC_START) &&
		(int'(h_cnt) < arcade_pkg::H_SYNC_START + arcade_pkg::H_SYNC_LEN);
	assign tim.vs       = (int'(v_cnt) >= arcade_pkg::V_SYNC_START) &&
		(int'(v_cnt) < arcade_pkg::V_SYNC_START + arcade_pkg::V_SYNC_LEN);
	assign tim.hb       = (int'(h_cnt) >= arcade_pkg::H_ACTIVE);
	assign tim.vb       = (int'(v_cnt) >= arcade_pkg::V_ACTIVE);
	assign tim.odd_line = v_cnt[0];

endmodule

// File: hw/input_mapper.sv
`timescale 1ns/1ps

module input_mapper (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [7:0]  joy_0,
	input  logic [7:0]  joy_1,
	shell_cfg_if.sink   cfg,
	output logic [1:0]  but_up,
	output logic [1:0]  but_down,
	output logic [1:0]  but_left,
	output logic [1:0]  but_right,
	output logic [1:0]  but_fire,
	output logic [1:0]  but_bomb,
	output logic [1:0]  but_coin,
	output logic [1:0]  but_select
);

	// Joystick bits from 0 upward are right, left, down, up, fire, bomb, coin and start
	logic [7:0] joy_q [2];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joy_q[0] <= '0;
			joy_q[1] <= '0;
		end else begin
			joy_q[0] <= joy_0;
			joy_q[1] <= joy_1;
		end
	end

	// Rotated stick turns a quarter clockwise, so up drives right and so on
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			but_right[p]  = ~(cfg.rotate ? joy_q[p][3] : joy_q[p][0]);
			but_left[p]   = ~(cfg.rotate ? joy_q[p][2] : joy_q[p][1]);
			but_down[p]   = ~(cfg.rotate ? joy_q[p][0] : joy_q[p][2]);
			but_up[p]     = ~(cfg.rotate ? joy_q[p][1] : joy_q[p][3]);
			but_fire[p]   = ~joy_q[p][4];
			but_bomb[p]   = ~joy_q[p][5];
			but_coin[p]   = ~joy_q[p][6];
			but_select[p] = ~joy_q[p][7];
		end
	end

endmodule

// File: hw/video_out.sv
`timescale 1ns/1ps

module video_out (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [1:0] core_r,
	input  logic [1:0] core_g,
	input  logic [1:0] core_b,
	vid_timing_if.sink tim,
	shell_cfg_if.sink  cfg,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic       blank;
	logic [5:0] prev_r;
	logic [5:0] prev_g;
	logic [5:0] prev_b;

	// Widen one channel, then blend with the last pixel and dim odd lines
	function automatic logic [5:0] shade(
		input logic [1:0]             c,
		input logic [5:0]             prev,
		input logic                   blend,
		input arcade_pkg::scan_mode_t mode,
		input logic                   odd
	);
		logic [6:0] sum;
		logic [5:0] v;
		logic [5:0] dim;
		sum = {1'b0, {3{c}}} + {1'b0, prev};
		v = blend ? sum[6:1] : {3{c}};
		case (mode)
			arcade_pkg::SCAN_25: dim = v - (v >> 2);
			arcade_pkg::SCAN_50: dim = v >> 1;
			arcade_pkg::SCAN_75: dim = v >> 2;
			default:             dim = v;
		endcase
		return odd ? dim : v;
	endfunction

	assign blank = tim.hb | tim.vb;

	//==========================================================================
	// Pixel registers load once per pixel
	//==========================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			prev_r <= '0;
			prev_g <= '0;
			prev_b <= '0;
		end else if (tim.ce_pix) begin
			// Sync goes through the same register stage as the colour
			vga_hs <= tim.hs;
			vga_vs <= tim.vs;
			if (blank) begin
				vga_r  <= '0;
				vga_g  <= '0;
				vga_b  <= '0;
				prev_r <= '0;
				prev_g <= '0;
				prev_b <= '0;
			end else begin
				vga_r  <= shade(core_r, prev_r, cfg.blend, cfg.scanlines, tim.odd_line);
				vga_g  <= shade(core_g, prev_g, cfg.blend, cfg.scanlines, tim.odd_line);
				vga_b  <= shade(core_b, prev_b, cfg.blend, cfg.scanlines, tim.odd_line);
				prev_r <= {3{core_r}};
				prev_g <= {3{core_g}};
				prev_b <= {3{core_b}};
			end
		end
	end

endmodule

// File: hw/sigma_dac.sv
`timescale 1ns/1ps

module sigma_dac (
	input  logic                            clk_sys,
	input  logic                            arst_n,
	input  logic [arcade_pkg::AUDIO_BITS-1:0] audio_in,
	output logic                            audio_out
);

	logic [arcade_pkg::AUDIO_BITS-1:0] acc;
	logic [arcade_pkg::AUDIO_BITS:0]   sum;

	// The carry out of the accumulator is the one-bit output stream
	assign sum = {1'b0, acc} + {1'b0, audio_in};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[arcade_pkg::AUDIO_BITS-1:0];
			audio_out <= sum[arcade_pkg::AUDIO_BITS];
		end
	end

endmodule

// File: hw/arcade_shell.sv
`timescale 1ns/1ps

module arcade_shell (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [1:0]                        wb_adr,
	input  logic [31:0]                       wb_dat_w,
	output logic [31:0]                       wb_dat_r,
	output logic                              wb_ack,
	input  logic [7:0]                        joy_0,
	input  logic [7:0]                        joy_1,
	input  logic [1:0]                        core_r,
	input  logic [1:0]                        core_g,
	input  logic [1:0]                        core_b,
	input  logic [arcade_pkg::AUDIO_BITS-1:0] core_audio,
	output logic                              core_reset,
	output logic                              core_ce_pix,
	output logic                              core_hblank,
	output logic                              core_vblank,
	output logic [1:0]                        but_up,
	output logic [1:0]                        but_down,
	output logic [1:0]                        but_left,
	output logic [1:0]                        but_right,
	output logic [1:0]                        but_fire,
	output logic [1:0]                        but_bomb,
	output logic [1:0]                        but_coin,
	output logic [1:0]                        but_select,
	output logic [5:0]                        vga_r,
	output logic [5:0]                        vga_g,
	output logic [5:0]                        vga_b,
	output logic                              vga_hs,
	output logic                              vga_vs,
	output logic                              audio_l
);

	vid_timing_if tim ();
	shell_cfg_if  cfg ();

	host_regs u_host_regs (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.cfg      (cfg)
	);

	video_timing u_video_timing (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.tim     (tim)
	);

	input_mapper u_input_mapper (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.cfg        (cfg),
		.but_up     (but_up),
		.but_down   (but_down),
		.but_left   (but_left),
		.but_right  (but_right),
		.but_fire   (but_fire),
		.but_bomb   (but_bomb),
		.but_coin   (but_coin),
		.but_select (but_select)
	);

	video_out u_video_out (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.core_r  (core_r),
		.core_g  (core_g),
		.core_b  (core_b),
		.tim     (tim),
		.cfg     (cfg),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	sigma_dac u_sigma_dac (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.audio_in  (core_audio),
		.audio_out (audio_l)
	);

	// The core runs from the shell's pixel enable and menu reset
	assign core_reset  = cfg.core_reset;
	assign core_ce_pix = tim.ce_pix;
	assign core_hblank = tim.hb;
	assign core_vblank = tim.vb;

endmodule

// File: test/shell_props.sv
`timescale 1ns/1ps

module shell_props (
	input logic       clk_sys,
	input logic       arst_n,
	input logic       wb_cyc,
	input logic       wb_stb,
	input logic       wb_ack,
	input logic       core_ce_pix,
	input logic       core_hblank,
	input logic       core_vblank,
	input logic [5:0] vga_r,
	input logic [5:0] vga_g,
	input logic [5:0] vga_b
);

	ack_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles in a row");

	ack_in_cycle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high without cyc and stb");

	ce_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		core_ce_pix |=> !core_ce_pix)
		else $error("ce_pix high on two consecutive clocks");

	// A blanked pixel clears all three colour registers
	blank_black: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(core_ce_pix && (core_hblank || core_vblank)) |=>
		((vga_r == 6'd0) && (vga_g == 6'd0) && (vga_b == 6'd0)))
		else $error("VGA colour not zero one pixel after blanking");

endmodule

bind arcade_shell shell_props u_props (
	.clk_sys     (clk_sys),
	.arst_n      (arst_n),
	.wb_cyc      (wb_cyc),
	.wb_stb      (wb_stb),
	.wb_ack      (wb_ack),
	.core_ce_pix (core_ce_pix),
	.core_hblank (core_hblank),
	.core_vblank (core_vblank),
	.vga_r       (vga_r),
	.vga_g       (vga_g),
	.vga_b       (vga_b)
);

// File: test/shell_checker.sv
`timescale 1ns/1ps

module shell_checker (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  int          test_id,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	input  logic [7:0]  joy_0,
	input  logic [7:0]  joy_1,
	input  logic [1:0]  core_r,
	input  logic [1:0]  core_g,
	input  logic [1:0]  core_b,
	input  logic [8:0]  core_audio,
	input  logic        core_reset,
	input  logic        core_ce_pix,
	input  logic        core_hblank,
	input  logic        core_vblank,
	input  logic [15:0] buttons,
	input  logic [17:0] vga_rgb,
	input  logic        vga_hs,
	input  logic        vga_vs,
	input  logic        audio_l,
	output int          err_total,
	output int          check_total
);

	// Model state advances on every rising edge
	logic        m_st;
	logic [31:0] m_status;
	logic [31:0] m_rdata;
	logic [7:0]  m_joy0;
	logic [7:0]  m_joy1;
	logic        m_ce;
	int          m_ce_cnt;
	int          m_h;
	int          m_v;
	logic [17:0] m_vga;
	logic [17:0] m_prev;
	logic        m_hs;
	logic        m_vs;
	logic [8:0]  m_acc;
	logic        m_dac;
	logic [8:0]  dac_in_last;
	logic        odd;
	int          sum;

	// Bookkeeping for the per-test lines, sync periods and DAC windows
	int          cur_test;
	int          test_checks;
	int          test_errs;
	logic        hs_prev;
	logic        vs_prev;
	logic        hs_seen;
	logic        vs_seen;
	int          hs_clks;
	int          lines;
	logic [8:0]  win_val;
	int          win_n;
	int          win_ones;
	int          diff;

	initial begin
		err_total   = 0;
		check_total = 0;
		cur_test    = 0;
		test_checks = 0;
		test_errs   = 0;
		win_val     = '0;
		win_n       = 0;
		win_ones    = 0;
	end

	function automatic string test_name(input int id);
		case (id)
			1:       return "register access";
			2:       return "input mapping";
			3:       return "video timing";
			4:       return "pixel path";
			5:       return "audio dac";
			6:       return "core reset";
			default: return "unknown";
		endcase
	endfunction

	// Expected active-low pairs packed as {select, coin, bomb, fire, up, down, left, right}
	function automatic logic [15:0] expected_buttons(
		input logic [7:0] j0,
		input logic [7:0] j1,
		input logic       rot
	);
		logic [7:0]  m0;
		logic [7:0]  m1;
		logic [15:0] res;
		m0 = j0;
		m1 = j1;
		if (rot) begin
			// Up steers right, right steers down, down steers left, left steers up
			m0[0] = j0[3];
			m0[2] = j0[0];
			m0[1] = j0[2];
			m0[3] = j0[1];
			m1[0] = j1[3];
			m1[2] = j1[0];
			m1[1] = j1[2];
			m1[3] = j1[1];
		end
		for (int b = 0; b < 8; b++) begin
			res[2 * b]     = ~m0[b];
			res[2 * b + 1] = ~m1[b];
		end
		return res;
	endfunction

	function automatic logic [5:0] pixel_value(
		input logic [1:0]  c,
		input logic [5:0]  prev,
		input logic [31:0] st,
		input logic        odd_line
	);
		int         v;
		logic [1:0] mode_bits;
		mode_bits = st[arcade_pkg::STATUS_SCAN_HI:arcade_pkg::STATUS_SCAN_LO];
		// Three copies of a 2-bit value equal the value times 6'b010101
		v = 21 * int'(c);
		if (st[arcade_pkg::STATUS_BIT_BLEND]) begin
			v = (v + int'(prev)) / 2;
		end
		if (odd_line) begin
			case (arcade_pkg::scan_mode_t'(mode_bits))
				arcade_pkg::SCAN_25: v = v - v / 4;
				arcade_pkg::SCAN_50: v = v / 2;
				arcade_pkg::SCAN_75: v = v / 4;
				default:             v = v;
			endcase
		end
		return 6'(v);
	endfunction

	task automatic report_check(input logic ok, input string msg);
		check_total++;
		test_checks++;
		if (!ok) begin
			err_total++;
			test_errs++;
			$display("[FAIL] t=%0t: %s", $time, msg);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		report_check(got === exp, $sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	//==========================================================================
	// The model steps on the same edges as the DUT
	//==========================================================================
	always @(posedge clk_sys) begin
		if (!arst_n) begin
			m_st     = 1'b0;
			m_status = '0;
			m_joy0   = '0;
			m_joy1   = '0;
			m_ce     = 1'b0;
			m_ce_cnt = 0;
			m_h      = 0;
			m_v      = 0;
			m_vga    = '0;
			m_prev   = '0;
			m_hs     = 1'b0;
			m_vs     = 1'b0;
			m_acc    = '0;
			m_dac    = 1'b0;
		end else begin
			// Pixel stage sees the timing and settings from before this edge
			if (m_ce) begin
				m_hs = (m_h >= arcade_pkg::H_SYNC_START) &&
					(m_h < arcade_pkg::H_SYNC_START + arcade_pkg::H_SYNC_LEN);
				m_vs = (m_v >= arcade_pkg::V_SYNC_START) &&
					(m_v < arcade_pkg::V_SYNC_START + arcade_pkg::V_SYNC_LEN);
				if (m_h >= arcade_pkg::H_ACTIVE || m_v >= arcade_pkg::V_ACTIVE) begin
					m_vga  = '0;
					m_prev = '0;
				end else begin
					odd   = (m_v % 2) == 1;
					m_vga = {pixel_value(core_r, m_prev[17:12], m_status, odd),
						pixel_value(core_g, m_prev[11:6], m_status, odd),
						pixel_value(core_b, m_prev[5:0], m_status, odd)};
					m_prev = {6'(21 * int'(core_r)), 6'(21 * int'(core_g)),
						6'(21 * int'(core_b))};
				end
				if (m_h == arcade_pkg::H_TOTAL - 1) begin
					m_h = 0;
					m_v = (m_v == arcade_pkg::V_TOTAL - 1) ? 0 : m_v + 1;
				end else begin
					m_h = m_h + 1;
				end
			end
			m_ce     = (m_ce_cnt == arcade_pkg::CE_DIV - 1);
			m_ce_cnt = (m_ce_cnt + 1) % arcade_pkg::CE_DIV;

			m_joy0 = joy_0;
			m_joy1 = joy_1;

			sum         = int'(m_acc) + int'(core_audio);
			m_dac       = (sum >= (1 << arcade_pkg::AUDIO_BITS));
			m_acc       = 9'(sum % (1 << arcade_pkg::AUDIO_BITS));
			dac_in_last = core_audio;

			// The bus goes last so that a write only reaches the settings after this edge
			if (m_st) begin
				m_st = 1'b0;
			end else if (wb_cyc && wb_stb) begin
				m_st = 1'b1;
				case (wb_adr)
					arcade_pkg::REG_STATUS: m_rdata = m_status;
					arcade_pkg::REG_ID:     m_rdata = arcade_pkg::BUILD_ID;
					default:                m_rdata = '0;
				endcase
				if (wb_we && wb_adr == arcade_pkg::REG_STATUS) begin
					m_status = wb_dat_w;
				end
			end
		end
	end

	//==========================================================================
	// Comparison runs half a clock after each edge
	//==========================================================================
	always @(negedge clk_sys) begin
		if (test_id != cur_test) begin
			if (cur_test >= 1 && cur_test <= 6) begin
				$display("test %0d %s: %0d checks, %0d errors, %s", cur_test,
					test_name(cur_test), test_checks, test_errs,
					(test_errs == 0) ? "ok" : "FAILED");
			end
			cur_test    = test_id;
			test_checks = 0;
			test_errs   = 0;
		end

		check_value("wb_ack", 32'(wb_ack), 32'(m_st));
		if (m_st) begin
			check_value("wb_dat_r", wb_dat_r, m_rdata);
		end
		check_value("core_reset", 32'(core_reset),
			32'(m_status[arcade_pkg::STATUS_BIT_RESET]));
		check_value("core_ce_pix", 32'(core_ce_pix), 32'(m_ce));
		check_value("core_hblank", 32'(core_hblank), 32'(m_h >= arcade_pkg::H_ACTIVE));
		check_value("core_vblank", 32'(core_vblank), 32'(m_v >= arcade_pkg::V_ACTIVE));
		check_value("buttons", 32'(buttons), 32'(expected_buttons(m_joy0, m_joy1,
			m_status[arcade_pkg::STATUS_BIT_ROTATE])));
		check_value("vga colour", 32'(vga_rgb), 32'(m_vga));
		check_value("vga_hs", 32'(vga_hs), 32'(m_hs));
		check_value("vga_vs", 32'(vga_vs), 32'(m_vs));
		check_value("audio_l", 32'(audio_l), 32'(m_dac));

		if (!arst_n) begin
			hs_prev = 1'b0;
			vs_prev = 1'b0;
			hs_seen = 1'b0;
			vs_seen = 1'b0;
			hs_clks = 0;
			lines   = 0;
		end else begin
			hs_clks++;
			if (vga_hs && !hs_prev) begin
				if (hs_seen) begin
					check_value("hs period", 32'(hs_clks),
						32'(arcade_pkg::H_TOTAL * arcade_pkg::CE_DIV));
				end
				hs_seen = 1'b1;
				hs_clks = 0;
				lines++;
			end
			if (vga_vs && !vs_prev) begin
				if (vs_seen) begin
					check_value("lines per frame", 32'(lines), 32'(arcade_pkg::V_TOTAL));
				end
				vs_seen = 1'b1;
				lines   = 0;
			end
			hs_prev = vga_hs;
			vs_prev = vga_vs;
		end

		// The density of ones is counted over windows where the input held still
		if (dac_in_last != win_val) begin
			win_val  = dac_in_last;
			win_n    = 0;
			win_ones = 0;
		end
		if (arst_n) begin
			win_ones += int'(audio_l);
			win_n++;
			if (win_n == (1 << arcade_pkg::AUDIO_BITS)) begin
				diff = win_ones - int'(win_val);
				report_check(diff >= -1 && diff <= 1, $sformatf(
					"audio_l gave %0d ones in %0d cycles for input %0d",
					win_ones, win_n, win_val));
				win_n    = 0;
				win_ones = 0;
			end
		end else begin
			win_n    = 0;
			win_ones = 0;
		end
	end

endmodule

// File: test/tb_arcade_shell.sv
`timescale 1ns/1ps

module tb_arcade_shell;

	localparam int FRAME_CLKS =
		arcade_pkg::H_TOTAL * arcade_pkg::V_TOTAL * arcade_pkg::CE_DIV;
	// The sequence takes about fifteen frames of 576 clocks
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk_sys;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic [7:0]  joy_0;
	logic [7:0]  joy_1;
	logic [1:0]  core_r;
	logic [1:0]  core_g;
	logic [1:0]  core_b;
	logic [8:0]  core_audio;
	logic        core_reset;
	logic        core_ce_pix;
	logic        core_hblank;
	logic        core_vblank;
	logic [1:0]  but_up;
	logic [1:0]  but_down;
	logic [1:0]  but_left;
	logic [1:0]  but_right;
	logic [1:0]  but_fire;
	logic [1:0]  but_bomb;
	logic [1:0]  but_coin;
	logic [1:0]  but_select;
	logic [5:0]  vga_r;
	logic [5:0]  vga_g;
	logic [5:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        audio_l;
	int          test_id;
	int          err_total;
	int          check_total;
	int          cycles;

	arcade_shell dut (.*);

	shell_checker u_check (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.test_id     (test_id),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.core_audio  (core_audio),
		.core_reset  (core_reset),
		.core_ce_pix (core_ce_pix),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.buttons     ({but_select, but_coin, but_bomb, but_fire,
			but_up, but_down, but_left, but_right}),
		.vga_rgb     ({vga_r, vga_g, vga_b}),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.audio_l     (audio_l),
		.err_total   (err_total),
		.check_total (check_total)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the run hung and did not finish within %0d clock cycles", cycles);
		$display("Test failed");
		$finish;
	end

	// Every call starts and ends 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		@(negedge clk_sys);
		while (!wb_ack) @(negedge clk_sys);
		// Hold the request through the edge that takes ack
		wait_cycles(1);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	//==========================================================================
	// Test sequence
	//==========================================================================
	initial begin
		void'($urandom(32'h38f4));
		arst_n     = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		joy_0      = '0;
		joy_1      = '0;
		core_r     = '0;
		core_g     = '0;
		core_b     = '0;
		core_audio = '0;
		test_id    = 0;
		wait_cycles(8);
		arst_n = 1'b1;
		wait_cycles(2);

		test_id = 1;
		bus_cycle(1'b0, arcade_pkg::REG_STATUS, '0);
		bus_cycle(1'b0, arcade_pkg::REG_ID, '0);
		repeat (40) begin
			bus_cycle(1'($urandom_range(1, 0)), 2'($urandom_range(3, 0)), $urandom);
		end

		test_id = 2;
		bus_cycle(1'b1, arcade_pkg::REG_STATUS, '0);
		repeat (30) begin
			joy_0 = 8'($urandom);
			joy_1 = 8'($urandom);
			wait_cycles(1);
		end
		bus_cycle(1'b1, arcade_pkg::REG_STATUS, 32'd1 << arcade_pkg::STATUS_BIT_ROTATE);
		repeat (30) begin
			joy_0 = 8'($urandom);
			joy_1 = 8'($urandom);
			wait_cycles(1);
		end
		joy_0 = '0;
		joy_1 = '0;

		test_id = 3;
		wait_cycles(2 * FRAME_CLKS);

		test_id = 4;
		for (int mode = 0; mode < 4; mode++) begin
			for (int blend = 0; blend < 2; blend++) begin
				bus_cycle(1'b1, arcade_pkg::REG_STATUS,
					(32'(mode) << arcade_pkg::STATUS_SCAN_LO) |
					(32'(blend) << arcade_pkg::STATUS_BIT_BLEND));
				repeat (FRAME_CLKS) begin
					core_r = 2'($urandom);
					core_g = 2'($urandom);
					core_b = 2'($urandom);
					wait_cycles(1);
				end
			end
		end

		test_id = 5;
		repeat (5) begin
			core_audio = 9'($urandom_range(511, 0));
			wait_cycles(540);
		end

		test_id = 6;
		bus_cycle(1'b1, arcade_pkg::REG_STATUS, 32'd1 << arcade_pkg::STATUS_BIT_RESET);
		wait_cycles(4);
		bus_cycle(1'b1, arcade_pkg::REG_STATUS, '0);
		wait_cycles(4);

		test_id = 7;
		wait_cycles(2);
		$display("Summary: %0d checks, %0d errors", check_total, err_total);
		if (err_total == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
hw/arcade_pkg.sv
hw/shell_if.sv
hw/host_regs.sv
hw/video_timing.sv
hw/input_mapper.sv
hw/video_out.sv
hw/sigma_dac.sv
hw/arcade_shell.sv
test/shell_props.sv
test/shell_checker.sv
test/tb_arcade_shell.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_arcade_shell

out=$(./obj_dir/Vtb_arcade_shell)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
